// File: compile.f
lab_pkg.sv
lab_bus_if.sv
lab_decode.sv
lab_read_mux.sv
lab_psg_dcrm.sv
lab_sound_mix.sv
lab_main.sv
tb_lab_main.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_lab_main
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_lab_main.sv
module tb_lab_main;

    localparam int K_SEL  = 0;
    localparam int K_GFX  = 1;
    localparam int K_READ = 2;

    // mixer gains in 4.4 and the filter settle limit
    localparam int FM_GAIN   = 240;
    localparam int PSG_GAIN  = 192;
    localparam int DC_LIMIT  = 16 * PSG_GAIN / 16;

    localparam logic [1:0] START = 2'b01;
    localparam logic [1:0] COIN  = 2'b10;

    logic                             clk;
    logic                             rst;
    logic                             cpu_cen;
    logic                             cen3;
    logic [1:0]                       cen_cnt;
    lab_pkg::addr_t                   addr;
    logic                             rnw;
    logic                             vma;
    lab_pkg::data_t                   cpu_dout;
    lab_pkg::data_t                   cpu_din;
    logic                             rom_cs;
    logic                             ram_cs;
    logic                             pal_cs;
    logic                             ym0_cs;
    logic                             ym1_cs;
    logic                             prot_cs;
    logic [lab_pkg::ROM_AW-1:0]       rom_addr;
    logic                             gfx_cs;
    logic [lab_pkg::GFX_AW-1:0]       gfx_addr;
    logic [5:0]                       joystick1;
    logic [5:0]                       joystick2;
    logic                             service;
    logic                             gfx_irqn;
    logic                             gfx_nmin;
    logic                             dip_pause;
    logic                             irq_ack;
    logic                             irq_n;
    logic                             nmi_n;
    logic signed [lab_pkg::SND_W-1:0] fm0_snd;
    logic signed [lab_pkg::SND_W-1:0] fm1_snd;
    logic [lab_pkg::PSG_W-1:0]        psg0_snd;
    logic [lab_pkg::PSG_W-1:0]        psg1_snd;
    logic                             snd_sample;
    logic signed [lab_pkg::SND_W-1:0] snd;
    logic                             sample;
    logic                             peak;

    int          checks;
    int          errors;
    int          timeouts;

    // stimulus table, one column per queue
    string          t_name[$];
    int             t_kind[$];
    lab_pkg::addr_t t_addr[$];
    logic           t_rnw[$];
    lab_pkg::data_t t_wdata[$];
    logic [5:0]     t_joy1[$];
    logic [5:0]     t_joy2[$];
    logic [15:0]    t_exp[$];

    lab_main dut (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .cen3(cen3),
        .addr(addr), .rnw(rnw), .vma(vma), .cpu_dout(cpu_dout), .cpu_din(cpu_din),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .pal_cs(pal_cs), .ym0_cs(ym0_cs),
        .ym1_cs(ym1_cs), .prot_cs(prot_cs), .rom_addr(rom_addr),
        .gfx_cs(gfx_cs), .gfx_addr(gfx_addr),
        .rom_data(8'h11), .ram_dout(8'h22), .gfx_dout(8'h33), .pal_dout(8'h44),
        .prot_dout(8'h55), .ym0_dout(8'h66), .ym1_dout(8'h77),
        .start_button(START), .coin_input(COIN), .joystick1(joystick1),
        .joystick2(joystick2), .service(service),
        .gfx_irqn(gfx_irqn), .gfx_nmin(gfx_nmin), .dip_pause(dip_pause),
        .irq_ack(irq_ack), .irq_n(irq_n), .nmi_n(nmi_n),
        .fm0_snd(fm0_snd), .fm1_snd(fm1_snd), .psg0_snd(psg0_snd), .psg1_snd(psg1_snd),
        .snd_sample(snd_sample), .snd(snd), .sample(sample), .peak(peak)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one-in-four strobes, cpu and sound on different phases
    always @(posedge clk) begin
        #1;
        cen_cnt = cen_cnt + 2'd1;
        cpu_cen = (cen_cnt == 2'd0);
        cen3    = (cen_cnt == 2'd2);
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic lab_pkg::data_t cabinet_value(input logic start, input logic [5:0] joy);
        return {start, 1'b1, joy[5], joy[4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    function automatic logic [15:0] gfx_expect(input lab_pkg::addr_t a);
        // bit 15 carries gfx_cs, address in the low 14 bits
        return {1'b1, 1'b0, 1'b1, ~a[12], a[11:0]};
    endfunction

    function automatic logic signed [15:0] mix_expect(input int a, input int b, input int c);
        longint s;
        s = (longint'(a) * FM_GAIN + longint'(b) * FM_GAIN + longint'(c) * PSG_GAIN) >>> 4;
        if (s > 32767) return 16'sh7fff;
        if (s < -32768) return -16'sh8000;
        return 16'(s);
    endfunction

    task automatic add_entry(input string name, input int kind, input lab_pkg::addr_t a,
                             input logic r, input lab_pkg::data_t wd, input logic [5:0] j1,
                             input logic [5:0] j2, input logic [15:0] e);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_addr.push_back(a);
        t_rnw.push_back(r);
        t_wdata.push_back(wd);
        t_joy1.push_back(j1);
        t_joy2.push_back(j2);
        t_exp.push_back(e);
    endtask

    task automatic write_bank(input logic [2:0] b);
        int n;
        addr     = 16'h0c00;
        rnw      = 1'b0;
        cpu_dout = {5'd0, b};
        n = 0;
        @(negedge clk);
        while (!cpu_cen && n < 8) begin
            n++;
            @(negedge clk);
        end
        if (!cpu_cen) begin
            timeouts++;
            $display("timeout: no cpu_cen strobe while writing the bank register");
        end
        step();
        rnw  = 1'b1;
        addr = 16'h0400;
    endtask

    task automatic cen3_strobes(input int count);
        int n;
        for (int k = 0; k < count; k++) begin
            n = 0;
            @(negedge clk);
            while (!cen3 && n < 8) begin
                n++;
                @(negedge clk);
            end
            if (!cen3) begin
                timeouts++;
                $display("timeout: the cen3 strobe did not arrive");
            end
            step();
        end
    endtask

    initial begin
        logic [5:0]  j;
        logic [16:0] rom_exp;
        int          mag;
        checks = 0;
        errors = 0;
        timeouts = 0;
        void'($urandom(32'h40de_ad50));
        rst = 1'b1;
        cen_cnt = 2'd0;
        cpu_cen = 1'b0;
        cen3 = 1'b0;
        addr = 16'h0400;
        rnw = 1'b1;
        vma = 1'b1;
        cpu_dout = 8'h00;
        joystick1 = 6'd0;
        joystick2 = 6'd0;
        service = 1'b0;
        gfx_irqn = 1'b1;
        gfx_nmin = 1'b1;
        dip_pause = 1'b1;
        irq_ack = 1'b0;
        fm0_snd = '0;
        fm1_snd = '0;
        psg0_snd = '0;
        psg1_snd = '0;
        snd_sample = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check("reset irq_n", 32'd1, 32'(irq_n));
        check("reset peak", 32'd0, 32'(peak));
        check("reset gfx_cs", 32'd0, 32'(gfx_cs));
        check("reset selects", 32'd0, 32'({rom_cs, ram_cs, pal_cs, ym0_cs, ym1_cs, prot_cs}));

        // selects as {rom, ram, pal, ym0, ym1, prot}
        add_entry("sel ym0", K_SEL, 16'h0800, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0004);
        add_entry("sel ym1", K_SEL, 16'h0900, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0002);
        add_entry("sel prot", K_SEL, 16'h0d00, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0001);
        add_entry("sel pal", K_SEL, 16'h1000, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0008);
        add_entry("sel ram", K_SEL, 16'h1800, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0010);
        add_entry("sel rom", K_SEL, 16'h8000, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0020);
        add_entry("gfx 2000", K_GFX, 16'h2000, 1'b1, 8'h00, 6'd0, 6'd0, gfx_expect(16'h2000));
        add_entry("gfx 3123", K_GFX, 16'h3123, 1'b1, 8'h00, 6'd0, 6'd0, gfx_expect(16'h3123));
        add_entry("read rom", K_READ, 16'h8000, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0011);
        add_entry("read ram", K_READ, 16'h1800, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0022);
        add_entry("read gfx", K_READ, 16'h2000, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0033);
        add_entry("read pal", K_READ, 16'h1000, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0044);
        add_entry("read prot", K_READ, 16'h0d00, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0055);
        add_entry("read ym0", K_READ, 16'h0800, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0066);
        add_entry("read ym1", K_READ, 16'h0900, 1'b1, 8'h00, 6'd0, 6'd0, 16'h0077);
        add_entry("read sys", K_READ, 16'h0b00, 1'b1, 8'h00, 6'd0, 6'd0,
                  {8'h00, 5'b11111, 1'b0, COIN});
        add_entry("read open", K_READ, 16'h0400, 1'b1, 8'h00, 6'd0, 6'd0, 16'h00ff);
        add_entry("read bank page", K_READ, 16'h0c00, 1'b1, 8'h00, 6'd0, 6'd0, 16'h00ff);
        for (int i = 0; i < 4; i++) begin
            j = 6'($urandom);
            add_entry("read p1", K_READ, 16'h0a01, 1'b1, 8'h00, j, ~j,
                      {8'h00, cabinet_value(START[0], j)});
            j = 6'($urandom);
            add_entry("read p2", K_READ, 16'h0a00, 1'b1, 8'h00, ~j, j,
                      {8'h00, cabinet_value(START[1], j)});
        end

        for (int i = 0; i < t_name.size(); i++) begin
            addr      = t_addr[i];
            rnw       = t_rnw[i];
            cpu_dout  = t_wdata[i];
            joystick1 = t_joy1[i];
            joystick2 = t_joy2[i];
            case (t_kind[i])
                K_SEL: begin
                    #1;
                    check(t_name[i], 32'(t_exp[i]),
                          32'({rom_cs, ram_cs, pal_cs, ym0_cs, ym1_cs, prot_cs}));
                end
                K_GFX: begin
                    step();
                    check(t_name[i], 32'(t_exp[i]), 32'({gfx_cs, 1'b0, gfx_addr}));
                end
                default: begin
                    repeat (3) step();
                    check(t_name[i], 32'(t_exp[i]), 32'(cpu_din));
                end
            endcase
            step();
        end

        // paged rom window follows the bank register
        for (int b = 0; b < 8; b++) begin
            write_bank(3'(b));
            rom_exp = {3'(b + 2), 14'h0123};
            addr = 16'h4123;
            #1;
            check("rom paged", 32'(rom_exp), 32'(rom_addr));
            addr = 16'h8123;
            #1;
            check("rom fixed", 32'h0000_0123, 32'(rom_addr));
            step();
        end
        addr = 16'h0400;

        gfx_irqn = 1'b0;
        step();
        check("irq falls", 32'd0, 32'(irq_n));
        repeat (3) step();
        gfx_irqn = 1'b1;
        step();
        check("irq holds", 32'd0, 32'(irq_n));
        irq_ack = 1'b1;
        step();
        irq_ack = 1'b0;
        check("irq ack", 32'd1, 32'(irq_n));
        dip_pause = 1'b0;
        gfx_irqn = 1'b0;
        repeat (3) step();
        check("irq masked", 32'd1, 32'(irq_n));
        gfx_irqn = 1'b1;
        dip_pause = 1'b1;
        step();
        check("irq no edge", 32'd1, 32'(irq_n));

        // nmi and sample strobe pass straight through
        gfx_nmin = 1'b0;
        snd_sample = 1'b1;
        #1;
        check("nmi copy low", 32'd0, 32'(nmi_n));
        check("sample copy high", 32'd1, 32'(sample));
        gfx_nmin = 1'b1;
        snd_sample = 1'b0;
        #1;
        check("nmi copy high", 32'd1, 32'(nmi_n));
        check("sample copy low", 32'd0, 32'(sample));
        step();

        fm0_snd = 16'sd1000;
        fm1_snd = -16'sd300;
        cen3_strobes(3);
        check("mix sum", 32'(mix_expect(1000, -300, 0)), 32'(snd));
        check("mix no peak", 32'd0, 32'(peak));
        fm0_snd = 16'sd20000;
        fm1_snd = 16'sd20000;
        cen3_strobes(3);
        check("mix sat high", 32'(mix_expect(20000, 20000, 0)), 32'(snd));
        check("mix peak high", 32'd1, 32'(peak));
        fm0_snd = -16'sd20000;
        fm1_snd = -16'sd20000;
        cen3_strobes(3);
        check("mix sat low", 32'(mix_expect(-20000, -20000, 0)), 32'(snd));
        check("mix peak low", 32'd1, 32'(peak));

        // constant psg level must be filtered out
        fm0_snd = '0;
        fm1_snd = '0;
        psg0_snd = 10'd300;
        psg1_snd = 10'd300;
        cen3_strobes(200);
        mag = (snd < 0) ? -int'(snd) : int'(snd);
        check("filter settles", 32'd1, 32'(mag < DC_LIMIT));

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: lab_main.sv
module lab_main #(
    parameter logic [7:0] FM_GAIN    = 8'hf0,
    parameter logic [7:0] PSG_GAIN   = 8'hc0,
    parameter int         DCRM_SHIFT = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_cen,
    input  logic                              cen3,
    // cpu bus
    input  lab_pkg::addr_t                    addr,
    input  logic                              rnw,
    input  logic                              vma,
    input  lab_pkg::data_t                    cpu_dout,
    output lab_pkg::data_t                    cpu_din,
    // selects and addresses
    output logic                              rom_cs,
    output logic                              ram_cs,
    output logic                              pal_cs,
    output logic                              ym0_cs,
    output logic                              ym1_cs,
    output logic                              prot_cs,
    output logic [lab_pkg::ROM_AW-1:0]        rom_addr,
    output logic                              gfx_cs,
    output logic [lab_pkg::GFX_AW-1:0]        gfx_addr,
    // read data sources
    input  lab_pkg::data_t                    rom_data,
    input  lab_pkg::data_t                    ram_dout,
    input  lab_pkg::data_t                    gfx_dout,
    input  lab_pkg::data_t                    pal_dout,
    input  lab_pkg::data_t                    prot_dout,
    input  lab_pkg::data_t                    ym0_dout,
    input  lab_pkg::data_t                    ym1_dout,
    // cabinet
    input  logic [1:0]                        start_button,
    input  logic [1:0]                        coin_input,
    input  logic [5:0]                        joystick1,
    input  logic [5:0]                        joystick2,
    input  logic                              service,
    // interrupts
    input  logic                              gfx_irqn,
    input  logic                              gfx_nmin,
    input  logic                              dip_pause,
    input  logic                              irq_ack,
    output logic                              irq_n,
    output logic                              nmi_n,
    // sound
    input  logic signed [lab_pkg::SND_W-1:0]  fm0_snd,
    input  logic signed [lab_pkg::SND_W-1:0]  fm1_snd,
    input  logic [lab_pkg::PSG_W-1:0]         psg0_snd,
    input  logic [lab_pkg::PSG_W-1:0]         psg1_snd,
    input  logic                              snd_sample,
    output logic signed [lab_pkg::SND_W-1:0]  snd,
    output logic                              sample,
    output logic                              peak
);

    localparam int PSG_SUM_W = lab_pkg::PSG_W + 1;

    logic [PSG_SUM_W-1:0]        psg_sum;
    logic signed [PSG_SUM_W-1:0] psg_ac;

    lab_bus_if bus ();

    assign bus.addr     = addr;
    assign bus.rnw      = rnw;
    assign bus.vma      = vma;
    assign bus.cpu_dout = cpu_dout;

    assign nmi_n  = gfx_nmin;
    assign sample = snd_sample;

    lab_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus       (bus.decoder),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .pal_cs    (pal_cs),
        .ym0_cs    (ym0_cs),
        .ym1_cs    (ym1_cs),
        .prot_cs   (prot_cs),
        .rom_addr  (rom_addr),
        .gfx_cs    (gfx_cs),
        .gfx_addr  (gfx_addr),
        .gfx_irqn  (gfx_irqn),
        .dip_pause (dip_pause),
        .irq_ack   (irq_ack),
        .irq_n     (irq_n)
    );

    lab_read_mux u_read_mux (
        .clk          (clk),
        .bus          (bus.reader),
        .rom_data     (rom_data),
        .ram_dout     (ram_dout),
        .gfx_dout     (gfx_dout),
        .pal_dout     (pal_dout),
        .prot_dout    (prot_dout),
        .ym0_dout     (ym0_dout),
        .ym1_dout     (ym1_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .cpu_din      (cpu_din)
    );

    // both psg outputs summed, one bit wider so it cannot wrap
    assign psg_sum = {1'b0, psg0_snd} + {1'b0, psg1_snd};

    lab_psg_dcrm #(
        .W     (PSG_SUM_W),
        .SHIFT (DCRM_SHIFT)
    ) u_dcrm (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen3),
        .din  (psg_sum),
        .dout (psg_ac)
    );

    lab_sound_mix #(
        .GAIN0 (FM_GAIN),
        .GAIN1 (FM_GAIN),
        .GAIN2 (PSG_GAIN),
        .W2    (PSG_SUM_W)
    ) u_mix (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen3),
        .ch0  (fm0_snd),
        .ch1  (fm1_snd),
        .ch2  (psg_ac),
        .snd  (snd),
        .peak (peak)
    );

endmodule

// File: lab_sound_mix.sv
module lab_sound_mix #(
    parameter logic [7:0] GAIN0 = 8'h10,
    parameter logic [7:0] GAIN1 = 8'h10,
    parameter logic [7:0] GAIN2 = 8'h10,
    parameter int         W2    = 11
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic signed [lab_pkg::SND_W-1:0]  ch0,
    input  logic signed [lab_pkg::SND_W-1:0]  ch1,
    input  logic signed [W2-1:0]              ch2,
    output logic signed [lab_pkg::SND_W-1:0]  snd,
    output logic                              peak
);

    // gains are unsigned 4.4, one sign bit added for the product
    localparam int GW = 9;
    localparam int PW = lab_pkg::SND_W + GW + 2;

    localparam logic signed [PW-1:0] SMAX = PW'((1 << (lab_pkg::SND_W - 1)) - 1);
    localparam logic signed [PW-1:0] SMIN = ~SMAX;

    logic signed [PW-1:0]             p0;
    logic signed [PW-1:0]             p1;
    logic signed [PW-1:0]             p2;
    logic signed [PW-1:0]             sum;
    logic signed [PW-1:0]             scaled;
    logic signed [lab_pkg::SND_W-1:0] sat;
    logic                             clip;

    assign p0 = PW'(ch0) * PW'($signed({1'b0, GAIN0}));
    assign p1 = PW'(ch1) * PW'($signed({1'b0, GAIN1}));
    assign p2 = PW'(ch2) * PW'($signed({1'b0, GAIN2}));

    assign sum    = p0 + p1 + p2;
    // drop the four fraction bits of the gain
    assign scaled = sum >>> 4;

    always_comb begin
        clip = 1'b1;
        if (scaled > SMAX) begin
            sat = SMAX[lab_pkg::SND_W-1:0];
        end else if (scaled < SMIN) begin
            sat = SMIN[lab_pkg::SND_W-1:0];
        end else begin
            sat  = scaled[lab_pkg::SND_W-1:0];
            clip = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            peak <= 1'b0;
        end else if (cen) begin
            peak <= clip;
        end
        if (cen) begin
            snd <= sat;
        end
    end

endmodule

// File: lab_psg_dcrm.sv
module lab_psg_dcrm #(
    parameter int W     = 11,
    parameter int SHIFT = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [W-1:0]        din,
    output logic signed [W-1:0] dout
);

    logic [W-1:0]        avg;
    logic signed [W:0]   diff;
    logic signed [W:0]   step;
    logic signed [W-1:0] diff_sat;

    // one extra bit so the difference never wraps
    assign diff = $signed({1'b0, din}) - $signed({1'b0, avg});
    assign step = diff >>> SHIFT;

    // clip to the signed output range
    always_comb begin
        if (diff[W] != diff[W-1]) begin
            diff_sat = diff[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
        end else begin
            diff_sat = diff[W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            avg  <= '0;
            dout <= '0;
        end else if (cen) begin
            avg  <= avg + step[W-1:0];
            dout <= diff_sat;
        end
    end

endmodule

// File: lab_read_mux.sv
module lab_read_mux (
    input  logic            clk,
    lab_bus_if.reader       bus,
    input  lab_pkg::data_t  rom_data,
    input  lab_pkg::data_t  ram_dout,
    input  lab_pkg::data_t  gfx_dout,
    input  lab_pkg::data_t  pal_dout,
    input  lab_pkg::data_t  prot_dout,
    input  lab_pkg::data_t  ym0_dout,
    input  lab_pkg::data_t  ym1_dout,
    input  logic [1:0]      start_button,
    input  logic [1:0]      coin_input,
    input  logic [5:0]      joystick1,
    input  logic [5:0]      joystick2,
    input  logic            service,
    output lab_pkg::data_t  cpu_din
);

    lab_pkg::data_t cabinet;
    lab_pkg::data_t sys_dout;
    lab_pkg::data_t ym_dout;

    // joystick bit order as wired on the cabinet connector
    function automatic lab_pkg::data_t cab_byte(input logic start, input logic [5:0] joy);
        cab_byte = {start, 1'b1, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    assign sys_dout = {5'b11111, service, coin_input};

    always_ff @(posedge clk) begin
        // player 1 on odd addresses
        cabinet <= bus.addr[0] ? cab_byte(start_button[0], joystick1)
                               : cab_byte(start_button[1], joystick2);
        ym_dout <= (bus.sel == lab_pkg::sel_ym && bus.addr[10:8] == lab_pkg::IO_PAGE_YM0)
                   ? ym0_dout : ym1_dout;
    end

    always_ff @(posedge clk) begin
        case (bus.sel)
            lab_pkg::sel_rom:  cpu_din <= rom_data;
            lab_pkg::sel_ram:  cpu_din <= ram_dout;
            lab_pkg::sel_gfx:  cpu_din <= gfx_dout;
            lab_pkg::sel_in:   cpu_din <= cabinet;
            lab_pkg::sel_ym:   cpu_din <= ym_dout;
            lab_pkg::sel_sys:  cpu_din <= sys_dout;
            lab_pkg::sel_pal:  cpu_din <= pal_dout;
            lab_pkg::sel_prot: cpu_din <= prot_dout;
            // open bus reads high
            default:           cpu_din <= 8'hff;
        endcase
    end

endmodule

// File: lab_decode.sv
module lab_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_cen,
    lab_bus_if.decoder                  bus,
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        pal_cs,
    output logic                        ym0_cs,
    output logic                        ym1_cs,
    output logic                        prot_cs,
    output logic [lab_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        gfx_cs,
    output logic [lab_pkg::GFX_AW-1:0]  gfx_addr,
    input  logic                        gfx_irqn,
    input  logic                        dip_pause,
    input  logic                        irq_ack,
    output logic                        irq_n
);

    logic                        io_win;
    logic                        pre_gfx;
    logic                        pre_cfg;
    logic                        in_cs;
    logic                        sys_cs;
    logic                        bank_cs;
    logic [lab_pkg::BANK_W-1:0]  bank;
    logic [lab_pkg::BANK_W-1:0]  page;
    logic                        irq_trig;
    logic                        irq_trig_l;

    // memory regions
    assign rom_cs  = (bus.addr[15:14] != 2'b00) && bus.rnw && bus.vma;
    assign ram_cs  = bus.addr[15:11] == 5'b00011;
    assign pal_cs  = bus.addr[15:11] == 5'b00010;
    assign pre_gfx = bus.addr[15:13] == 3'b001;
    assign pre_cfg = bus.addr[15:8] == 8'h00;

    // i/o window at 0800-0fff, sub-page in addr[10:8]
    assign io_win  = bus.addr[15:11] == 5'b00001;
    assign ym0_cs  = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_YM0;
    assign ym1_cs  = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_YM1;
    assign in_cs   = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_IN && bus.rnw;
    assign sys_cs  = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_SYS && bus.rnw;
    assign bank_cs = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_BANK && !bus.rnw;
    assign prot_cs = io_win && bus.addr[10:8] == lab_pkg::IO_PAGE_PROT;

    // read priority follows the original board
    always_comb begin
        if (rom_cs)                bus.sel = lab_pkg::sel_rom;
        else if (ram_cs)           bus.sel = lab_pkg::sel_ram;
        else if (pre_gfx|pre_cfg)  bus.sel = lab_pkg::sel_gfx;
        else if (in_cs)            bus.sel = lab_pkg::sel_in;
        else if (ym0_cs || ym1_cs) bus.sel = lab_pkg::sel_ym;
        else if (sys_cs)           bus.sel = lab_pkg::sel_sys;
        else if (pal_cs)           bus.sel = lab_pkg::sel_pal;
        else if (prot_cs)          bus.sel = lab_pkg::sel_prot;
        else                       bus.sel = lab_pkg::sel_none;
    end

    // paged rom at 4000-7fff, fixed rom above 8000
    assign page     = bank + lab_pkg::BANK_W'(lab_pkg::BANK_BASE);
    assign rom_addr = bus.addr[15] ? {{(lab_pkg::ROM_AW-15){1'b0}}, bus.addr[14:0]}
                                   : {page, bus.addr[13:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else if (cpu_cen && bank_cs) begin
            bank <= bus.cpu_dout[lab_pkg::BANK_W-1:0];
        end
    end

    // graphics select and address, one clk behind the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_cs <= 1'b0;
        end else begin
            gfx_cs <= pre_gfx | pre_cfg;
        end
        gfx_addr <= {pre_gfx, ~bus.addr[12] & pre_gfx, bus.addr[11:0]};
    end

    // vblank interrupt, set on the rising edge of the trigger
    assign irq_trig = ~gfx_irqn & dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_l <= irq_trig;
            // acknowledge has priority over a new edge
            if (irq_ack) begin
                irq_n <= 1'b1;
            end else if (irq_trig && !irq_trig_l) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

// File: lab_bus_if.sv
interface lab_bus_if;

    // cpu side of the bus
    lab_pkg::addr_t addr;
    logic           rnw;
    logic           vma;
    lab_pkg::data_t cpu_dout;

    // read source chosen by the decoder
    lab_pkg::sel_e  sel;

    // address decoder
    modport decoder (
        input  addr,
        input  rnw,
        input  vma,
        input  cpu_dout,
        output sel
    );

    // read data multiplexer
    modport reader (
        input  addr,
        input  sel
    );

endinterface

// File: lab_pkg.sv
package lab_pkg;

    // cpu bus types
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // read data source, one value per mapped region
    typedef enum logic [3:0] {
        sel_none,
        sel_rom,
        sel_ram,
        sel_gfx,
        sel_pal,
        sel_in,
        sel_sys,
        sel_ym,
        sel_prot
    } sel_e;

    // rom and graphics addressing
    localparam int ROM_AW    = 17;
    localparam int GFX_AW    = 14;
    localparam int BANK_W    = 3;
    localparam int BANK_BASE = 2;

    // sub-pages of the 0800-0fff i/o window, from addr[10:8]
    localparam logic [2:0] IO_PAGE_YM0  = 3'd0;
    localparam logic [2:0] IO_PAGE_YM1  = 3'd1;
    localparam logic [2:0] IO_PAGE_IN   = 3'd2;
    localparam logic [2:0] IO_PAGE_SYS  = 3'd3;
    localparam logic [2:0] IO_PAGE_BANK = 3'd4;
    localparam logic [2:0] IO_PAGE_PROT = 3'd5;

    // sound sample widths
    localparam int PSG_W = 10;
    localparam int SND_W = 16;

endpackage
